// File: common/dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Word address width, addresses count 64-bit words
`define DMA_ADDR_W 24

// Data word width
`define DMA_DATA_W 64

// Length register width in words
`define DMA_LEN_W 16

// Longest burst in words
// Bursts never cross a multiple of this
`define DMA_BURST_LEN 8

// Data FIFO entries per channel, also depth of the grant-order FIFO
`define DMA_FIFO_DEPTH 16

`define DMA_N_CHAN 2    // Read channels sharing the memory port

`endif

// File: common/dma_pkg.sv
`include "dma_macros.svh"

package dma_pkg;

	// Burst request towards memory
	typedef struct packed {
		logic [`DMA_ADDR_W-1:0]          addr;    // First word address
		logic [$clog2(`DMA_BURST_LEN):0] len;     // 1 to DMA_BURST_LEN words
	} mem_req_t;

	// One beat of read data
	typedef struct packed {
		logic [`DMA_DATA_W-1:0] data;
		logic                   last;             // Final beat of a burst
	} mem_rsp_t;

	// Register write on the config port
	typedef struct packed {
		logic [1:0]             index;
		logic [`DMA_ADDR_W-1:0] value;
	} cfg_wr_t;

	// Register map
	localparam logic [1:0] REG_ADDR = 2'd0;   // Start word address
	localparam logic [1:0] REG_LEN  = 2'd1;   // Transfer length in words
	localparam logic [1:0] REG_GO   = 2'd2;   // Value ignored

endpackage

// File: dma/dma_fifo.sv
module dma_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 16
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       push,
	input  T                           push_data,
	input  logic                       pop,
	output T                           pop_data,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] free
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push  = push && (count != CNT_W'(DEPTH));    // Full FIFO drops the push
	assign do_pop   = pop && (count != '0);
	assign empty    = (count == '0);
	assign free     = CNT_W'(DEPTH) - count;
	assign pop_data = mem[rd_ptr];                          // Show-ahead read

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: dma/dma_read_channel.sv
`include "dma_macros.svh"

module dma_read_channel (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   cfg_req,
	input  dma_pkg::cfg_wr_t       cfg_wr,
	output logic                   cfg_ack,
	output logic                   burst_req,
	output dma_pkg::mem_req_t      burst,
	input  logic                   burst_ack,
	input  logic                   rsp_valid,
	input  dma_pkg::mem_rsp_t      rsp,
	output logic                   out_req,
	output logic [`DMA_DATA_W-1:0] out_data,
	input  logic                   out_ack,
	output logic                   busy
);
	localparam int BURST  = `DMA_BURST_LEN;
	localparam int DEPTH  = `DMA_FIFO_DEPTH;
	localparam int LEN_W  = `DMA_LEN_W;
	localparam int OFF_W  = $clog2(BURST);
	localparam int BLEN_W = $clog2(BURST) + 1;
	localparam int CNT_W  = $clog2(DEPTH + 1);

	logic [`DMA_ADDR_W-1:0] addr_q;
	logic [LEN_W-1:0]       len_q;
	logic [`DMA_ADDR_W-1:0] iss_addr;     // Next burst address
	logic [LEN_W-1:0]       iss_left;     // Words not yet requested
	logic [LEN_W-1:0]       out_left;     // Words not yet handed out
	logic [CNT_W-1:0]       reserved;     // Requested but not yet in the FIFO
	logic [CNT_W-1:0]       free;
	logic                   empty;
	logic                   pop;
	dma_pkg::mem_rsp_t      head;
	logic [BLEN_W-1:0]      to_bound;
	logic [BLEN_W-1:0]      blen;
	logic                   issue;
	logic                   cfg_take;
	logic                   go;

	// Register port
	assign cfg_take = cfg_req && !cfg_ack;
	assign go       = cfg_take && !busy && (cfg_wr.index == dma_pkg::REG_GO) && (len_q != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cfg_ack <= 1'b0;
		else if (cfg_take)
			cfg_ack <= 1'b1;
		else if (!cfg_req)
			cfg_ack <= 1'b0;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			addr_q <= '0;
			len_q  <= '0;
		end else if (cfg_take && !busy) begin     // Acked but ignored when busy
			case (cfg_wr.index)
				dma_pkg::REG_ADDR: addr_q <= cfg_wr.value;
				dma_pkg::REG_LEN:  len_q  <= cfg_wr.value[LEN_W-1:0];
				default: ;
			endcase
		end
	end

	// Burst size up to the next BURST boundary
	assign to_bound = BLEN_W'(BURST) - BLEN_W'(iss_addr[OFF_W-1:0]);
	assign blen     = (iss_left < LEN_W'(to_bound)) ? BLEN_W'(iss_left) : to_bound;

	// Only ask when a full burst fits beside what is already promised
	assign issue = busy && (iss_left != '0) && !burst_req && !burst_ack &&
		((free - reserved) >= CNT_W'(BURST));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			burst_req <= 1'b0;
			iss_addr  <= '0;
			iss_left  <= '0;
			out_left  <= '0;
		end else if (go) begin
			busy     <= 1'b1;
			iss_addr <= addr_q;
			iss_left <= len_q;
			out_left <= len_q;
		end else if (busy) begin
			if (issue) begin
				burst_req <= 1'b1;
			end else if (burst_req && burst_ack) begin
				burst_req <= 1'b0;
				iss_addr  <= iss_addr + `DMA_ADDR_W'(burst.len);
				iss_left  <= iss_left - LEN_W'(burst.len);
			end
			if (out_req && out_ack)
				out_left <= out_left - 1'b1;
			// Done once the last word's ack has dropped
			if (out_left == '0 && !out_req && !out_ack && !burst_req && !burst_ack)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			burst <= '{addr: iss_addr, len: blen};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			reserved <= '0;
		else
			reserved <= reserved + (issue ? CNT_W'(blen) : CNT_W'(0))
				- (rsp_valid ? CNT_W'(1) : CNT_W'(0));
	end

	dma_fifo #(
		.T     (dma_pkg::mem_rsp_t),
		.DEPTH (DEPTH)
	) data_fifo_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (rsp_valid),
		.push_data (rsp),
		.pop       (pop),
		.pop_data  (head),
		.empty     (empty),
		.free      (free)
	);

	// Output stream, next word once the previous ack is gone
	assign pop = busy && !out_req && !out_ack && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_req <= 1'b0;
		else if (pop)
			out_req <= 1'b1;
		else if (out_req && out_ack)
			out_req <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (pop)
			out_data <= head.data;
	end

endmodule

// File: hdl/mem_arbiter.sv
`include "dma_macros.svh"

module mem_arbiter #(
	parameter int N = 2
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic [N-1:0]      burst_req,
	input  dma_pkg::mem_req_t burst [N],
	output logic [N-1:0]      burst_ack,
	output logic              mem_req,
	output dma_pkg::mem_req_t mem_burst,
	input  logic              mem_ack,
	input  logic              mem_rsp_valid,
	input  dma_pkg::mem_rsp_t mem_rsp,
	output logic [N-1:0]      rsp_valid,
	output dma_pkg::mem_rsp_t rsp
);
	localparam int IDX_W = (N > 1) ? $clog2(N) : 1;
	localparam int DEPTH = `DMA_FIFO_DEPTH;

	typedef logic [IDX_W-1:0] idx_t;

	idx_t                       rr_ptr;     // Highest priority this round
	idx_t                       cur_idx;    // Owner of the memory cycle
	idx_t                       win_idx;
	idx_t                       ord_head;
	logic [N-1:0]               cand;
	logic                       win_valid;
	logic                       port_idle;
	logic                       grant;
	logic                       ord_empty;
	logic [$clog2(DEPTH+1)-1:0] ord_free;

	// A raised req with its ack still high is the same burst
	assign cand      = burst_req & ~burst_ack;
	assign port_idle = !mem_req && !mem_ack;
	assign grant     = port_idle && win_valid && (ord_free != '0);

	always_comb begin
		int idx;
		win_valid = 1'b0;
		win_idx   = '0;
		for (int k = 0; k < N; k++) begin
			idx = (int'(rr_ptr) + k) % N;
			if (!win_valid && cand[idx]) begin
				win_valid = 1'b1;
				win_idx   = idx_t'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_req   <= 1'b0;
			cur_idx   <= '0;
			rr_ptr    <= '0;
			burst_ack <= '0;
		end else begin
			if (grant) begin
				mem_req <= 1'b1;
				cur_idx <= win_idx;
				rr_ptr  <= (win_idx == idx_t'(N - 1)) ? '0 : win_idx + 1'b1;
			end else if (mem_req && mem_ack) begin
				mem_req <= 1'b0;
			end
			for (int i = 0; i < N; i++) begin
				if (mem_req && mem_ack && cur_idx == idx_t'(i))
					burst_ack[i] <= 1'b1;           // Relay memory ack
				else if (burst_ack[i] && !burst_req[i])
					burst_ack[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant)
			mem_burst <= burst[win_idx];
	end

	// Grant order, one entry per burst until its last beat
	dma_fifo #(
		.T     (idx_t),
		.DEPTH (DEPTH)
	) ord_fifo_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (grant),
		.push_data (win_idx),
		.pop       (mem_rsp_valid && mem_rsp.last),
		.pop_data  (ord_head),
		.empty     (ord_empty),
		.free      (ord_free)
	);

	// Response steering
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rsp_valid <= '0;
		else
			rsp_valid <= (mem_rsp_valid && !ord_empty) ? (N'(1) << ord_head) : '0;
	end

	always_ff @(posedge clk) begin
		rsp <= mem_rsp;
	end

endmodule

// File: hdl/dma_subsys_top.sv
`include "dma_macros.svh"

module dma_subsys_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`DMA_N_CHAN-1:0] cfg_req,
	input  dma_pkg::cfg_wr_t       cfg_wr [`DMA_N_CHAN],
	output logic [`DMA_N_CHAN-1:0] cfg_ack,
	output logic [`DMA_N_CHAN-1:0] out_req,
	output logic [`DMA_DATA_W-1:0] out_data [`DMA_N_CHAN],
	input  logic [`DMA_N_CHAN-1:0] out_ack,
	output logic [`DMA_N_CHAN-1:0] busy,
	output logic                   mem_req,
	output dma_pkg::mem_req_t      mem_burst,
	input  logic                   mem_ack,
	input  logic                   mem_rsp_valid,
	input  dma_pkg::mem_rsp_t      mem_rsp
);
	logic [`DMA_N_CHAN-1:0] burst_req;
	logic [`DMA_N_CHAN-1:0] burst_ack;
	logic [`DMA_N_CHAN-1:0] rsp_valid;
	dma_pkg::mem_req_t      burst [`DMA_N_CHAN];
	dma_pkg::mem_rsp_t      rsp;                  // Shared beat, steered by rsp_valid

	for (genvar c = 0; c < `DMA_N_CHAN; c++) begin : g_chan
		dma_read_channel chan_i (
			.clk       (clk),
			.arst_n    (arst_n),
			.cfg_req   (cfg_req[c]),
			.cfg_wr    (cfg_wr[c]),
			.cfg_ack   (cfg_ack[c]),
			.burst_req (burst_req[c]),
			.burst     (burst[c]),
			.burst_ack (burst_ack[c]),
			.rsp_valid (rsp_valid[c]),
			.rsp       (rsp),
			.out_req   (out_req[c]),
			.out_data  (out_data[c]),
			.out_ack   (out_ack[c]),
			.busy      (busy[c])
		);
	end

	mem_arbiter #(
		.N (`DMA_N_CHAN)
	) arb_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.burst_req     (burst_req),
		.burst         (burst),
		.burst_ack     (burst_ack),
		.mem_req       (mem_req),
		.mem_burst     (mem_burst),
		.mem_ack       (mem_ack),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp       (mem_rsp),
		.rsp_valid     (rsp_valid),
		.rsp           (rsp)
	);

endmodule

// File: tests/tb_mem_model.sv
module tb_mem_model (
	input  logic              clk,
	input  logic              mem_req,
	input  dma_pkg::mem_req_t mem_burst,
	output logic              mem_ack,
	output logic              mem_rsp_valid,
	output dma_pkg::mem_rsp_t mem_rsp
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WORDS = 1024;

	logic [63:0]       words [WORDS];
	logic [15:0]       lfsr;
	dma_pkg::mem_req_t pend [16];    // Accepted bursts waiting for their beats
	logic [3:0]        acc_ptr;
	logic [3:0]        done_ptr;

	// Galois LFSR, one step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// Four-phase request side
	initial begin : accept
		mem_ack = 1'b0;
		acc_ptr = '0;
		forever begin
			@(posedge clk);
			if (mem_req && !mem_ack) begin
				pend[acc_ptr] = mem_burst;
				#2;
				acc_ptr = acc_ptr + 1'b1;
				mem_ack = 1'b1;
			end else if (!mem_req && mem_ack) begin
				#2;
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : beats
		dma_pkg::mem_req_t b;
		int                gap;
		mem_rsp_valid = 1'b0;
		mem_rsp       = '0;
		done_ptr      = '0;
		lfsr          = 16'd13985;
		for (int a = 0; a < WORDS; a++)
			words[a[9:0]] = rand_bits(64) ^ 64'(a);
		forever begin
			@(posedge clk);
			if (acc_ptr != done_ptr) begin
				b        = pend[done_ptr];
				done_ptr = done_ptr + 1'b1;
				gap      = int'(rand_bits(3));    // 0 to 7 idle cycles
				repeat (gap) @(posedge clk);
				for (int i = 0; i < int'(b.len); i++) begin
					#2;
					mem_rsp_valid = 1'b1;
					mem_rsp = '{data: words[b.addr[9:0] + 10'(i)],
						last: (i == int'(b.len) - 1)};
					@(posedge clk);
				end
				#2;
				mem_rsp_valid = 1'b0;
			end
		end
	end

endmodule

// File: tests/dma_tb.sv
`include "dma_macros.svh"

module dma_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TOTAL_WORDS = 120;    // Sum of all transfer lengths below
	localparam int MEM_LAT_MAX = 12;     // Worst case cycles from mem_req to first beat

	logic                   clk = 1'b0;
	logic                   arst_n;
	logic [1:0]             cfg_req;
	dma_pkg::cfg_wr_t       cfg_wr [2];
	logic [1:0]             cfg_ack;
	logic [1:0]             out_req;
	logic [`DMA_DATA_W-1:0] out_data [2];
	logic [1:0]             out_ack;
	logic [1:0]             busy;
	logic                   mem_req;
	dma_pkg::mem_req_t      mem_burst;
	logic                   mem_ack;
	logic                   mem_rsp_valid;
	dma_pkg::mem_rsp_t      mem_rsp;

	logic [15:0]            lfsr = 16'd13985;
	logic [23:0]            base [2];         // Start address of the current transfer
	int                     first_idx [2];    // Count of seen words when it began
	int                     seen [2];         // Words compared so far
	logic [63:0]            got_word [2];
	int                     got_cnt [2];
	int                     max_delay [2];    // Longest consumer ack delay
	int                     wait_left [2];
	logic [1:0]             ack_nx;
	logic [1:0]             take;
	logic [63:0]            word_nx [2];
	logic                   track_ch0;
	int                     requested0;
	int                     popped0;

	always #20 clk = ~clk;

	dma_subsys_top dut_i (.*);

	tb_mem_model mem_i (.*);

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// k-th word of a transfer is the memory word at start + k
	function automatic logic [63:0] expected_word(input logic [23:0] start, input int k);
		logic [9:0] idx;
		idx = start[9:0] + 10'(k);
		return mem_i.words[idx];
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic reg_write(input logic ch, input logic [1:0] idx, input logic [23:0] val);
		@(posedge clk);
		#2;
		cfg_wr[ch]  = '{index: idx, value: val};
		cfg_req[ch] = 1'b1;
		do begin
			@(posedge clk);
		end while (!cfg_ack[ch]);
		#2;
		cfg_req[ch] = 1'b0;
		do begin
			@(posedge clk);
		end while (cfg_ack[ch]);
		#2;
	endtask

	task automatic load_regs(input logic ch, input logic [23:0] addr, input int len);
		first_idx[ch] = seen[ch];
		base[ch]      = addr;
		reg_write(ch, dma_pkg::REG_ADDR, addr);
		reg_write(ch, dma_pkg::REG_LEN, 24'(len));
	endtask

	task automatic start_transfer(input logic ch);
		reg_write(ch, dma_pkg::REG_GO, '0);
		check($sformatf("busy[%0d]", ch), 64'(busy[ch]), 64'd1);
	endtask

	task automatic wait_done(input logic ch, input int len);
		do begin
			@(posedge clk);
		end while (busy[ch]);
		repeat (2) @(posedge clk);
		#2;
		check($sformatf("word count of channel %0d", ch), 64'(seen[ch] - first_idx[ch]),
			64'(len));
		check($sformatf("out_req[%0d]", ch), 64'(out_req[ch]), 64'd0);
	endtask

	// Consumer decision for one channel at a clock edge
	task automatic decide_ack(input logic ch);
		if (out_ack[ch]) begin
			if (!out_req[ch])
				ack_nx[ch] = 1'b0;
		end else if (out_req[ch]) begin
			if (wait_left[ch] < 0)
				wait_left[ch] = int'(rand_bits(5)) % (max_delay[ch] + 1);
			if (wait_left[ch] == 0) begin
				ack_nx[ch]    = 1'b1;
				take[ch]      = 1'b1;
				word_nx[ch]   = out_data[ch];
				wait_left[ch] = -1;
			end else begin
				wait_left[ch]--;
			end
		end
	endtask

	task automatic compare_word(input logic ch);
		if (got_cnt[ch] != seen[ch]) begin
			check($sformatf("out_data[%0d]", ch), got_word[ch],
				expected_word(base[ch], seen[ch] - first_idx[ch]));
			seen[ch]++;
		end
	endtask

	initial begin : consumers
		out_ack      = '0;
		got_cnt[0]   = 0;
		got_cnt[1]   = 0;
		wait_left[0] = -1;
		wait_left[1] = -1;
		forever begin
			@(posedge clk);
			ack_nx = out_ack;
			take   = '0;
			decide_ack(1'b0);
			decide_ack(1'b1);
			#2;
			out_ack = ack_nx;
			if (take[0]) begin
				got_word[0] = word_nx[0];
				got_cnt[0]++;
			end
			if (take[1]) begin
				got_word[1] = word_nx[1];
				got_cnt[1]++;
			end
		end
	end

	initial begin : compare
		seen[0] = 0;
		seen[1] = 0;
		forever begin
			@(posedge clk);
			compare_word(1'b0);
			compare_word(1'b1);
		end
	end

	// Burst shape on the memory port and channel 0 space while tracked
	initial begin : monitor
		logic mem_req_q;
		logic out_req_q;
		logic track_q;
		mem_req_q  = 1'b0;
		out_req_q  = 1'b0;
		track_q    = 1'b0;
		requested0 = 0;
		popped0    = 0;
		forever begin
			@(posedge clk);
			if (track_ch0 && !track_q) begin
				requested0 = 0;
				popped0    = 0;
			end
			if (out_req[0] && !out_req_q)
				popped0++;
			if (mem_req && !mem_req_q) begin
				check("mem_burst.len in 1 to 8",
					64'(mem_burst.len != '0 && mem_burst.len <= 4'd8), 64'd1);
				check("mem_burst inside an 8-word block",
					64'(({1'b0, mem_burst.addr[2:0]} + mem_burst.len) <= 4'd8), 64'd1);
				if (track_ch0) begin
					requested0 += int'(mem_burst.len);
					check("channel 0 words in flight at most 16",
						64'((requested0 - popped0) <= 16), 64'd1);
				end
			end
			mem_req_q = mem_req;
			out_req_q = out_req[0];
			track_q   = track_ch0;
		end
	end

	initial begin : watchdog
		repeat (TOTAL_WORDS * (MEM_LAT_MAX + 40)) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run hung",
			TOTAL_WORDS * (MEM_LAT_MAX + 40));
		$display("test failed");
		$fatal(1);
	end

	initial begin : main
		arst_n       = 1'b0;
		cfg_req      = '0;
		cfg_wr[0]    = '0;
		cfg_wr[1]    = '0;
		track_ch0    = 1'b0;
		max_delay[0] = 3;
		max_delay[1] = 3;
		base[0]      = '0;
		base[1]      = '0;
		first_idx[0] = 0;
		first_idx[1] = 0;
		repeat (3) @(posedge clk);
		#2;
		arst_n = 1'b1;

		// Aligned 8 words
		load_regs(1'b0, 24'd64, 8);
		start_transfer(1'b0);
		wait_done(1'b0, 8);

		// Unaligned start split at block edges
		load_regs(1'b0, 24'd205, 21);
		start_transfer(1'b0);
		wait_done(1'b0, 21);

		// Both channels at once
		load_regs(1'b0, 24'd300, 19);
		load_regs(1'b1, 24'd517, 14);
		start_transfer(1'b0);
		start_transfer(1'b1);
		wait_done(1'b0, 19);
		wait_done(1'b1, 14);

		// Slow consumer on channel 0
		max_delay[0] = 30;
		track_ch0    = 1'b1;
		load_regs(1'b0, 24'd600, 40);
		start_transfer(1'b0);
		wait_done(1'b0, 40);
		track_ch0    = 1'b0;
		max_delay[0] = 3;

		// Writes while busy change nothing
		load_regs(1'b1, 24'd700, 12);
		start_transfer(1'b1);
		reg_write(1'b1, dma_pkg::REG_ADDR, 24'd900);
		reg_write(1'b1, dma_pkg::REG_LEN, 24'd5);
		reg_write(1'b1, dma_pkg::REG_GO, '0);
		check("busy[1]", 64'(busy[1]), 64'd1);
		wait_done(1'b1, 12);
		load_regs(1'b1, 24'd900, 6);
		start_transfer(1'b1);
		wait_done(1'b1, 6);

		$display("test passed");
		$finish;
	end

endmodule

// File: dma_subsys.f
+incdir+common
common/dma_pkg.sv
dma/dma_fifo.sv
dma/dma_read_channel.sv
hdl/mem_arbiter.sv
hdl/dma_subsys_top.sv
tests/tb_mem_model.sv
tests/dma_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing
TOP      ?= dma_tb
FILELIST ?= dma_subsys.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run fails with a nonzero status when the testbench stops with an error
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
